// ==== hdl/aes_pkg.sv ====
`default_nettype none

package aes_pkg;

  typedef logic [7:0]  aes_byte_t;
  typedef logic [31:0] aes_word_t;

  // word 0 is the most significant word
  typedef aes_word_t [0:3] aes_key_t;

  // 128-bit block, byte 0 and column 0 sit in the top bits
  typedef union packed {
    aes_byte_t [0:15] b;  // byte view, shiftrows and output
    aes_word_t [0:3]  c;  // column view, mixcolumns and addroundkey
  } aes_state_u;

  localparam int AES_ROUNDS = 10;
  localparam int KS_WORDS   = 8;  // 16-bit words per block

  typedef logic [15:0] ks_word_t;

  typedef struct packed {
    aes_key_t     key;
    logic [127:0] block;  // nonce in the top 64 bits, counter below
    logic         run;
  } ctr_cfg_t;

  // round constants, entry 0 feeds round key 1
  localparam logic [0:9][7:0] RCON = {
    8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
    8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
  };

  // forward s-box, one row of the table per line
  localparam logic [0:255][7:0] SBOX = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  function automatic aes_byte_t sub_byte(aes_byte_t x);
    return SBOX[x];
  endfunction

endpackage

`default_nettype wire

// ==== hdl/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [5:0]  adr;  // byte address
    logic [31:0] dat_w;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat_r;
  } wb_rsp_t;

  // register map, key0 holds the top key word
  localparam logic [5:0] REG_KEY0     = 6'h00;
  localparam logic [5:0] REG_KEY1     = 6'h04;
  localparam logic [5:0] REG_KEY2     = 6'h08;
  localparam logic [5:0] REG_KEY3     = 6'h0c;
  localparam logic [5:0] REG_NONCE_HI = 6'h10;
  localparam logic [5:0] REG_NONCE_LO = 6'h14;
  localparam logic [5:0] REG_CTR_HI   = 6'h18;
  localparam logic [5:0] REG_CTR_LO   = 6'h1c;
  localparam logic [5:0] REG_CTRL     = 6'h20;  // bit 0 run
  localparam logic [5:0] REG_STATUS   = 6'h24;  // bit 0 busy, read only

endpackage

`default_nettype wire

// ==== hdl/ctr_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctr_regs (
  input  wire                     clk,
  input  wire                     rst,
  input  wire  wb_pkg::wb_req_t   wb_req,
  output wb_pkg::wb_rsp_t         wb_rsp,
  output aes_pkg::ctr_cfg_t       cfg,
  input  wire                     ctr_advance,
  input  wire                     busy
);
  import aes_pkg::*;
  import wb_pkg::*;

  aes_key_t    key_q;
  logic [63:0] nonce_q;
  logic [63:0] ctr_q;
  logic        run_q;
  logic        ack_q;
  logic [31:0] dat_r_q;
  logic        req;
  logic        wr;
  logic        ctr_wr;
  logic [31:0] rd_data;

  assign req    = wb_req.cyc & wb_req.stb & ~ack_q;  // no second ack while stb lingers
  assign wr     = req & wb_req.we;
  assign ctr_wr = wr & ((wb_req.adr == REG_CTR_HI) | (wb_req.adr == REG_CTR_LO));

  always_comb begin
    case (wb_req.adr)
      REG_KEY0, REG_KEY1, REG_KEY2, REG_KEY3: rd_data = key_q[wb_req.adr[3:2]];
      REG_NONCE_HI: rd_data = nonce_q[63:32];
      REG_NONCE_LO: rd_data = nonce_q[31:0];
      REG_CTR_HI:   rd_data = ctr_q[63:32];
      REG_CTR_LO:   rd_data = ctr_q[31:0];
      REG_CTRL:     rd_data = {31'd0, run_q};
      REG_STATUS:   rd_data = {31'd0, busy};
      default:      rd_data = 32'd0;  // unmapped
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      key_q   <= '0;
      nonce_q <= '0;
      ctr_q   <= '0;
      run_q   <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= req;
      if (ctr_advance && !ctr_wr)
        ctr_q <= ctr_q + 64'd1;  // full 64-bit carry wraps around
      if (wr) begin
        case (wb_req.adr)
          REG_KEY0, REG_KEY1, REG_KEY2, REG_KEY3: key_q[wb_req.adr[3:2]] <= wb_req.dat_w;
          REG_NONCE_HI: nonce_q[63:32] <= wb_req.dat_w;
          REG_NONCE_LO: nonce_q[31:0]  <= wb_req.dat_w;
          REG_CTR_HI:   ctr_q[63:32]   <= wb_req.dat_w;
          REG_CTR_LO:   ctr_q[31:0]    <= wb_req.dat_w;
          REG_CTRL:     run_q          <= wb_req.dat_w[0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req)
      dat_r_q <= rd_data;
  end

  assign wb_rsp.ack   = ack_q;
  assign wb_rsp.dat_r = dat_r_q;

  assign cfg.key   = key_q;
  assign cfg.block = {nonce_q, ctr_q};
  assign cfg.run   = run_q;

  // one ack per request and the master lets go of stb after it
  a_ack_single: assert property (@(posedge clk) disable iff (rst)
    ack_q |=> !ack_q && !wb_req.stb);

endmodule

`default_nettype wire

// ==== hdl/key_expand.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_expand (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  load,
  input  wire aes_pkg::aes_key_t key,
  input  wire                  step,
  output aes_pkg::aes_key_t    round_key
);
  import aes_pkg::*;

  aes_key_t   key_q;  // key of the round just applied
  logic [3:0] idx_q;  // rcon index
  aes_byte_t  rc;
  aes_word_t  rot_sub;

  assign rc = (idx_q < 4'(AES_ROUNDS)) ? RCON[idx_q] : 8'h00;

  // rotword then subword on the last word, rcon into the top byte
  assign rot_sub = {sub_byte(key_q[3][23:16]) ^ rc,
                    sub_byte(key_q[3][15:8]),
                    sub_byte(key_q[3][7:0]),
                    sub_byte(key_q[3][31:24])};

  always_comb begin
    round_key[0] = key_q[0] ^ rot_sub;
    for (int i = 1; i < 4; i++)
      round_key[i] = key_q[i] ^ round_key[i-1];  // chained xor
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      idx_q <= 4'd0;
    else if (load)
      idx_q <= 4'd0;
    else if (step)
      idx_q <= idx_q + 4'd1;
  end

  always_ff @(posedge clk) begin
    if (load)
      key_q <= key;
    else if (step)
      key_q <= round_key;  // advance one round
  end

endmodule

`default_nettype wire

// ==== hdl/aes_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_core (
  input  wire                    clk,
  input  wire                    rst,
  input  wire aes_pkg::ctr_cfg_t cfg,
  output logic                   ctr_advance,
  output logic                   busy,
  output aes_pkg::aes_state_u    blk,
  output logic                   blk_valid,
  input  wire                    blk_taken
);
  import aes_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_ROUND, ST_HOLD} core_st_e;

  core_st_e   st_q;
  logic [3:0] rnd_q;  // round being applied, 1 to 10
  aes_state_u state_q;
  aes_state_u sub_s;
  aes_state_u shift_s;
  aes_state_u mix_s;
  aes_state_u next_s;
  aes_key_t   round_key;
  logic       start;
  logic       last;

  function automatic aes_byte_t xtime(aes_byte_t x);
    return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic aes_word_t mix_col(aes_word_t col);
    aes_byte_t a0;
    aes_byte_t a1;
    aes_byte_t a2;
    aes_byte_t a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  assign start = (st_q == ST_IDLE) & cfg.run;
  assign last  = (rnd_q == 4'(AES_ROUNDS));  // final round has no mixcolumns
  assign busy  = (st_q != ST_IDLE);
  assign blk   = state_q;

  key_expand u_key (
    .clk       (clk),
    .rst       (rst),
    .load      (start),
    .key       (cfg.key),
    .step      (st_q == ST_ROUND),
    .round_key (round_key)
  );

  // one full round per cycle
  always_comb begin
    for (int i = 0; i < 16; i++)
      sub_s.b[i] = sub_byte(state_q.b[i]);
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++)
        shift_s.b[4*c + r] = sub_s.b[4*((c + r) % 4) + r];  // row r rotates left by r
    end
    for (int c = 0; c < 4; c++) begin
      mix_s.c[c]  = last ? shift_s.c[c] : mix_col(shift_s.c[c]);
      next_s.c[c] = mix_s.c[c] ^ round_key[c];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      st_q        <= ST_IDLE;
      rnd_q       <= 4'd0;
      ctr_advance <= 1'b0;
      blk_valid   <= 1'b0;
    end else begin
      ctr_advance <= start;
      case (st_q)
        ST_IDLE: if (start) begin
          st_q  <= ST_ROUND;
          rnd_q <= 4'd1;
        end
        ST_ROUND: if (last)
          st_q <= ST_HOLD;
        else
          rnd_q <= rnd_q + 4'd1;
        ST_HOLD: if (blk_taken) begin  // block handed over, free again
          st_q      <= ST_IDLE;
          blk_valid <= 1'b0;
        end else begin
          blk_valid <= 1'b1;  // one settle cycle after round 10
        end
        default: st_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start)
      state_q.c <= cfg.block ^ cfg.key;  // initial addroundkey
    else if (st_q == ST_ROUND)
      state_q <= next_s;
  end

  a_rnd_range: assert property (@(posedge clk) disable iff (rst)
    rnd_q <= 4'(AES_ROUNDS));

  a_blk_hold: assert property (@(posedge clk) disable iff (rst)
    blk_valid && !blk_taken |=> blk_valid && $stable(blk));

endmodule

`default_nettype wire

// ==== hdl/keystream_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module keystream_out (
  input  wire                     clk,
  input  wire                     rst,
  input  wire aes_pkg::aes_state_u blk,
  input  wire                     blk_valid,
  output logic                    blk_taken,
  output aes_pkg::ks_word_t       ks_word,
  output logic                    ks_valid,
  input  wire                     ks_ready
);
  import aes_pkg::*;

  aes_state_u blk_q;
  logic       full_q;
  logic [2:0] idx_q;  // next word to send

  assign blk_taken = blk_valid & ~full_q;
  assign ks_valid  = full_q;

  // byte pair 2i, 2i+1, top word first
  assign ks_word = {blk_q.b[{idx_q, 1'b0}], blk_q.b[{idx_q, 1'b1}]};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      full_q <= 1'b0;
      idx_q  <= 3'd0;
    end else if (blk_taken) begin
      full_q <= 1'b1;
      idx_q  <= 3'd0;
    end else if (ks_valid && ks_ready) begin
      idx_q <= idx_q + 3'd1;
      if (idx_q == 3'(KS_WORDS - 1))
        full_q <= 1'b0;  // last word accepted
    end
  end

  always_ff @(posedge clk) begin
    if (blk_taken)
      blk_q <= blk;
  end

  a_word_hold: assert property (@(posedge clk) disable iff (rst)
    ks_valid && !ks_ready |=> ks_valid && $stable(ks_word));

endmodule

`default_nettype wire

// ==== hdl/ctr_keystream_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctr_keystream_top (
  input  wire                   clk,
  input  wire                   rst,
  input  wire wb_pkg::wb_req_t  wb_req,
  output wb_pkg::wb_rsp_t       wb_rsp,
  output aes_pkg::ks_word_t     ks_word,
  output logic                  ks_valid,
  input  wire                   ks_ready
);
  import aes_pkg::*;

  ctr_cfg_t   cfg;
  logic       ctr_advance;
  logic       busy;
  aes_state_u blk;
  logic       blk_valid;
  logic       blk_taken;

  // key, nonce, counter and run
  ctr_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .cfg         (cfg),
    .ctr_advance (ctr_advance),
    .busy        (busy)
  );

  aes_core u_core (
    .clk         (clk),
    .rst         (rst),
    .cfg         (cfg),
    .ctr_advance (ctr_advance),
    .busy        (busy),
    .blk         (blk),
    .blk_valid   (blk_valid),
    .blk_taken   (blk_taken)
  );

  keystream_out u_out (
    .clk       (clk),
    .rst       (rst),
    .blk       (blk),
    .blk_valid (blk_valid),
    .blk_taken (blk_taken),
    .ks_word   (ks_word),
    .ks_valid  (ks_valid),
    .ks_ready  (ks_ready)
  );

endmodule

`default_nettype wire

// ==== sim/tb_ctr_keystream.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ctr_keystream;
  import aes_pkg::*;
  import wb_pkg::*;

  localparam int REC_A        = 0;  // sp800-38a ctr vectors
  localparam int REC_B        = 7;  // fips-197 single block
  localparam int BUS_TIMEOUT  = 20;
  localparam int WORD_TIMEOUT = 2000;
  localparam int QUIET_CYCLES = 40;  // well past the 12-cycle block latency

  logic        clk;
  logic        rst;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  ks_word_t    ks_word;
  logic        ks_valid;
  logic        ks_ready = 1'b0;
  logic [1:0]  ready_mode;  // 0 low, 1 high, 2 random
  logic [31:0] rnd_state = 32'd29628;
  logic [31:0] rd;
  logic [63:0] ctr_exp;
  int          blocks;

  logic [127:0] golden [0:10];
  ks_word_t     words_q [$];  // accepted words in order

  ctr_keystream_top dut0 (
    .clk      (clk),
    .rst      (rst),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .ks_word  (ks_word),
    .ks_valid (ks_valid),
    .ks_ready (ks_ready)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_bus_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
    if (act !== exp)
      report_failure($sformatf("ERROR: %s expected %h got %h", name, exp, act));
  endtask

  task automatic check_ks_word(input string name, input ks_word_t exp, input ks_word_t act);
    if (act !== exp)
      report_failure($sformatf("ERROR: %s expected %h got %h", name, exp, act));
  endtask

  // one classic cycle with stb dropped on the edge that shows ack
  task automatic bus_cycle(input logic we, input logic [5:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int n;
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, dat_w: wdata};
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > BUS_TIMEOUT)
        report_failure($sformatf("no wishbone ack at address %h", addr));
    end while (!wb_rsp.ack);
    rdata = wb_rsp.dat_r;
    wb_req <= '0;
  endtask

  task automatic wb_write(input logic [5:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, addr, data, unused);
  endtask

  task automatic wb_read(input logic [5:0] addr, output logic [31:0] data);
    bus_cycle(1'b0, addr, 32'd0, data);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst        <= 1'b1;
    wb_req     <= '0;
    ready_mode <= 2'd0;
    repeat (4) @(posedge clk);
    words_q.delete();
    rst <= 1'b0;
  endtask

  // key words then nonce and counter from 0x00 upward
  task automatic load_record(input int base);
    logic [255:0] src;
    src = {golden[base], golden[base + 1]};
    for (int i = 0; i < 8; i++)
      wb_write(REG_KEY0 + 6'(4 * i), src[255 - 32 * i -: 32]);
  endtask

  task automatic readback_record(input int base);
    logic [255:0] src;
    logic [31:0]  data;
    src = {golden[base], golden[base + 1]};
    for (int i = 0; i < 8; i++) begin
      wb_read(REG_KEY0 + 6'(4 * i), data);
      check_bus_word($sformatf("reg[%h]", REG_KEY0 + 6'(4 * i)), src[255 - 32 * i -: 32], data);
    end
  endtask

  task automatic check_blocks(input int base);
    int       n;
    int       total;
    ks_word_t exp;
    total = KS_WORDS * int'(golden[base + 2][31:0]);
    n = 0;
    while (words_q.size() < total) begin
      @(posedge clk);
      n++;
      if (n > WORD_TIMEOUT)
        report_failure("keystream words did not arrive in time");
    end
    for (int w = 0; w < total; w++) begin
      exp = golden[base + 3 + w / KS_WORDS][127 - 16 * (w % KS_WORDS) -: 16];
      check_ks_word($sformatf("ks_word[%0d]", w), exp, words_q[w]);
    end
  endtask

  task automatic drain_keystream();
    int n;
    int quiet;
    n = 0;
    quiet = 0;
    while (quiet < QUIET_CYCLES) begin
      @(posedge clk);
      n++;
      quiet = ks_valid ? 0 : quiet + 1;
      if (n > WORD_TIMEOUT)
        report_failure("keystream kept flowing after run was cleared");
    end
  endtask

  // records every word accepted on an edge
  always @(posedge clk) begin
    if (!rst && ks_valid && ks_ready)
      words_q.push_back(ks_word);
  end

  always @(posedge clk) begin
    case (ready_mode)
      2'd0: ks_ready <= 1'b0;
      2'd1: ks_ready <= 1'b1;
      default: begin
        rnd_state = xorshift32(rnd_state);
        ks_ready <= rnd_state[7];
      end
    endcase
  end

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    wb_req     = '0;
    ready_mode = 2'd0;
    $readmemh("sim/ctr_golden.hex", golden);
    if (^golden[10] === 1'bx)
      report_failure("golden file sim/ctr_golden.hex could not be read");
    apply_reset();

    load_record(REC_A);
    readback_record(REC_A);
    wb_read(REG_STATUS, rd);
    check_bus_word("status", 32'd0, rd);

    wb_write(REG_CTRL, 32'd1);
    wb_read(REG_STATUS, rd);  // core busy while ks_ready is still low
    check_bus_word("status", 32'd1, rd);
    ready_mode <= 2'd1;
    check_blocks(REC_A);

    apply_reset();  // same vectors again with back-pressure
    load_record(REC_A);
    ready_mode <= 2'd2;
    wb_write(REG_CTRL, 32'd1);
    check_blocks(REC_A);

    wb_write(REG_CTRL, 32'd0);
    drain_keystream();
    if (words_q.size() % KS_WORDS != 0)
      report_failure("a keystream block ended part way through its words");
    blocks  = words_q.size() / KS_WORDS;
    ctr_exp = golden[REC_A + 1][63:0] + 64'(blocks);
    wb_read(REG_CTR_LO, rd);
    check_bus_word("ctr_lo", ctr_exp[31:0], rd);
    wb_read(REG_CTR_HI, rd);
    check_bus_word("ctr_hi", ctr_exp[63:32], rd);
    wb_read(REG_STATUS, rd);
    check_bus_word("status", 32'd0, rd);

    words_q.delete();  // nothing in flight after the drain
    ready_mode <= 2'd1;
    load_record(REC_B);
    wb_write(REG_CTRL, 32'd1);
    check_blocks(REC_B);

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/ctr_golden.hex ====
// one 128-bit word per line: key, nonce and counter, block count, expected blocks
// record a from word 0 (sp800-38a ctr), record b from word 7 (fips-197 c.1)
2b7e151628aed2a6abf7158809cf4f3c
f0f1f2f3f4f5f6f7f8f9fafbfcfdfeff
00000000000000000000000000000004
ec8cdf7398607cb0f2d21675ea9ea1e4
362b7c3c6773516318a077d7fc5073ae
6a2cc3787889374fbeb4c81b17ba6c44
e89c399ff0f198c6d40a31db156cabfe
000102030405060708090a0b0c0d0e0f
00112233445566778899aabbccddeeff
00000000000000000000000000000001
69c4e0d86a7b0430d8cdb78070b4c55a

// ==== sources.f ====
hdl/aes_pkg.sv
hdl/wb_pkg.sv
hdl/ctr_regs.sv
hdl/key_expand.sv
hdl/aes_core.sv
hdl/keystream_out.sv
hdl/ctr_keystream_top.sv
sim/tb_ctr_keystream.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ctr_keystream \
		-f sources.f --Mdir obj_dir
	./obj_dir/Vtb_ctr_keystream | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
